/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f list.f --top-module tb_id_stage \
		-Mdir obj_dir -o sim_id_stage

run: compile
	./obj_dir/sim_id_stage > sim.log 2>&1 ; cat sim.log
	@! grep -q "Test failed" sim.log
	@grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* hdl/branch_resolve.sv */
`timescale 1ns/1ns
`include "id_settings.svh"

module branch_resolve (
	input  id_pkg::alu_op_e        alu_op_i,
	input  logic [`ID_WORD_W-1:0]  pc_i,
	input  logic [`ID_WORD_W-1:0]  inst_i,
	input  logic [`ID_WORD_W-1:0]  src1_i,
	input  logic [`ID_WORD_W-1:0]  src2_i,
	output id_pkg::jump_sel_e      jtsel_o,
	output logic [`ID_WORD_W-1:0]  jump_addr_o
);
	import id_pkg::*;

	logic [`ID_WORD_W-1:0] pc_seq;
	logic [`ID_WORD_W-1:0] br_off;
	logic                  neg;
	logic                  zero;
	logic                  taken;

	assign pc_seq = pc_i + `ID_WORD_W'(`ID_PC_STEP);
	assign br_off = {{(`ID_WORD_W-18){inst_i[15]}}, inst_i[15:0], 2'b00}; // word offset
	assign neg    = src1_i[`ID_WORD_W-1];
	assign zero   = (src1_i == '0);

	always_comb begin
		case (alu_op_i)
			OP_BEQ:  taken = (src1_i == src2_i);
			OP_BNE:  taken = (src1_i != src2_i);
			OP_BGEZ: taken = !neg;
			OP_BLTZ: taken = neg;
			OP_BGTZ: taken = !neg && !zero;
			OP_BLEZ: taken = neg || zero;
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		jtsel_o     = JT_SEQ;
		jump_addr_o = '0;
		case (alu_op_i)
			OP_J, OP_JAL: begin
				jtsel_o     = JT_ABS;
				jump_addr_o = {pc_seq[`ID_WORD_W-1 -: 4], inst_i[25:0], 2'b00};
			end
			OP_JR: begin
				jtsel_o     = JT_REG;
				jump_addr_o = src1_i;
			end
			default: begin
				if (taken) begin
					jtsel_o     = JT_BRANCH;
					jump_addr_o = pc_seq + br_off;
				end
			end
		endcase
	end

	always_comb begin
		if (jtsel_o == JT_BRANCH)
			a_branch_only: assert (alu_op_i inside {OP_BEQ, OP_BNE, OP_BGEZ, OP_BLTZ,
				OP_BGTZ, OP_BLEZ})
			else $error("branch target selected for non-branch op %s", alu_op_i.name());
	end

endmodule

/* hdl/id_capture.sv */
`timescale 1ns/1ns
`include "id_settings.svh"

module id_capture (
	input  logic                    cpu_clk_i,
	input  logic                    rst_n_i,
	input  logic                    req_i,
	input  logic [`ID_WORD_W-1:0]   inst_i,
	input  logic [`ID_WORD_W-1:0]   pc_i,
	input  logic [`ID_WORD_W-1:0]   rs_data_i,
	input  logic [`ID_WORD_W-1:0]   rt_data_i,
	input  logic                    exe_wreg_i,
	input  logic [`ID_RADDR_W-1:0]  exe_wa_i,
	input  logic [`ID_WORD_W-1:0]   exe_wd_i,
	input  logic                    mem_wreg_i,
	input  logic [`ID_RADDR_W-1:0]  mem_wa_i,
	input  logic [`ID_WORD_W-1:0]   mem_wd_i,
	output logic                    ack_o,
	output logic                    load_o,
	output logic [`ID_WORD_W-1:0]   cap_inst_o,
	output logic [`ID_WORD_W-1:0]   cap_pc_o,
	output logic [`ID_WORD_W-1:0]   cap_rs_data_o,
	output logic [`ID_WORD_W-1:0]   cap_rt_data_o,
	output logic                    cap_exe_wreg_o,
	output logic [`ID_RADDR_W-1:0]  cap_exe_wa_o,
	output logic [`ID_WORD_W-1:0]   cap_exe_wd_o,
	output logic                    cap_mem_wreg_o,
	output logic [`ID_RADDR_W-1:0]  cap_mem_wa_o,
	output logic [`ID_WORD_W-1:0]   cap_mem_wd_o
);
	import id_pkg::*;

	cap_state_e state_q;
	logic       take;

	assign take = (state_q == ST_IDLE) && req_i; // new request sampled

	always_ff @(posedge cpu_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= ST_IDLE;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (req_i)
						state_q <= ST_LOAD;
				end
				ST_LOAD: state_q <= ST_ACK; // results register on this edge
				ST_ACK: begin
					if (!req_i)
						state_q <= ST_IDLE;
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge cpu_clk_i) begin
		if (take) begin
			cap_inst_o     <= inst_i;
			cap_pc_o       <= pc_i;
			cap_rs_data_o  <= rs_data_i;
			cap_rt_data_o  <= rt_data_i;
			cap_exe_wreg_o <= exe_wreg_i;
			cap_exe_wa_o   <= exe_wa_i;
			cap_exe_wd_o   <= exe_wd_i;
			cap_mem_wreg_o <= mem_wreg_i;
			cap_mem_wa_o   <= mem_wa_i;
			cap_mem_wd_o   <= mem_wd_i;
		end
	end

	assign load_o = (state_q == ST_LOAD);
	assign ack_o  = (state_q == ST_ACK);

	// producer has to keep req up until it has seen ack
	a_ack_with_req: assert property (@(posedge cpu_clk_i) disable iff (!rst_n_i)
		!req_i |=> !$rose(ack_o));

	a_load_pulse: assert property (@(posedge cpu_clk_i) disable iff (!rst_n_i)
		load_o |=> !load_o);

endmodule

/* hdl/id_pkg.sv */
`include "id_settings.svh"

package id_pkg;

	// immediate forms share the op of their register form
	typedef enum logic [4:0] {
		OP_NOP,
		OP_ADD,
		OP_ADDU,
		OP_SUB,
		OP_SUBU,
		OP_SLT,
		OP_SLTU,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_NOR,
		OP_LUI,
		OP_SLL,
		OP_SRL,
		OP_SRA,
		OP_BEQ,
		OP_BNE,
		OP_BGEZ,
		OP_BLTZ,
		OP_BGTZ,
		OP_BLEZ,
		OP_J,
		OP_JAL,
		OP_JR
	} alu_op_e;

	typedef enum logic [1:0] {IMM_NONE, IMM_SEXT, IMM_ZEXT, IMM_UPPER} imm_kind_e;

	typedef enum logic [1:0] {FWD_REG, FWD_EXE, FWD_MEM} fwd_sel_e;

	typedef enum logic [1:0] {JT_SEQ, JT_ABS, JT_REG, JT_BRANCH} jump_sel_e;

	typedef enum logic {EXC_NONE, EXC_RI} exc_e;

	typedef enum logic [1:0] {ST_IDLE, ST_LOAD, ST_ACK} cap_state_e;

endpackage

/* hdl/id_result.sv */
`timescale 1ns/1ns
`include "id_settings.svh"

module id_result (
	input  logic                    cpu_clk_i,
	input  logic                    rst_n_i,
	input  logic                    load_i,
	input  logic [`ID_WORD_W-1:0]   pc_i,
	input  logic                    illegal_i,
	input  id_pkg::alu_op_e         alu_op_i,
	input  logic [`ID_WORD_W-1:0]   src1_i,
	input  logic [`ID_WORD_W-1:0]   src2_i,
	input  logic                    wreg_i,
	input  logic [`ID_RADDR_W-1:0]  wa_i,
	input  id_pkg::jump_sel_e       jtsel_i,
	input  logic [`ID_WORD_W-1:0]   jump_addr_i,
	output id_pkg::alu_op_e         alu_op_o,
	output logic [`ID_WORD_W-1:0]   src1_o,
	output logic [`ID_WORD_W-1:0]   src2_o,
	output logic                    wreg_o,
	output logic [`ID_RADDR_W-1:0]  wa_o,
	output id_pkg::jump_sel_e       jtsel_o,
	output logic [`ID_WORD_W-1:0]   jump_addr_o,
	output logic [`ID_WORD_W-1:0]   ret_addr_o,
	output id_pkg::exc_e            exc_o
);
	import id_pkg::*;

	always_ff @(posedge cpu_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			alu_op_o <= OP_NOP;
			wreg_o   <= 1'b0;
			jtsel_o  <= JT_SEQ;
			exc_o    <= EXC_NONE;
		end else if (load_i) begin
			alu_op_o <= alu_op_i;
			wreg_o   <= wreg_i && !illegal_i;             // reserved op never writes
			jtsel_o  <= illegal_i ? JT_SEQ : jtsel_i;
			exc_o    <= illegal_i ? EXC_RI : EXC_NONE;
		end
	end

	always_ff @(posedge cpu_clk_i) begin
		if (load_i) begin
			src1_o      <= src1_i;
			src2_o      <= src2_i;
			wa_o        <= wa_i;
			jump_addr_o <= jump_addr_i;
			ret_addr_o  <= pc_i + `ID_WORD_W'(2 * `ID_PC_STEP); // skips the delay slot
		end
	end

	// a reserved op never reaches writeback
	a_ri_no_write: assert property (@(posedge cpu_clk_i) disable iff (!rst_n_i)
		exc_o == EXC_RI |-> !wreg_o);

endmodule

/* hdl/id_settings.svh */
`ifndef ID_SETTINGS_SVH
`define ID_SETTINGS_SVH

// datapath and register file geometry
`define ID_WORD_W   32
`define ID_RADDR_W  5

// jal writes its return address here
`define ID_LINK_REG 31

// byte distance between two instructions
`define ID_PC_STEP  4

`endif

/* hdl/id_stage.sv */
`timescale 1ns/1ns
`include "id_settings.svh"

module id_stage (
	input  logic                    cpu_clk_i,
	input  logic                    rst_n_i,
	input  logic                    req_i,
	output logic                    ack_o,
	input  logic [`ID_WORD_W-1:0]   inst_i,
	input  logic [`ID_WORD_W-1:0]   pc_i,
	input  logic [`ID_WORD_W-1:0]   rs_data_i,
	input  logic [`ID_WORD_W-1:0]   rt_data_i,
	input  logic                    exe_wreg_i,
	input  logic [`ID_RADDR_W-1:0]  exe_wa_i,
	input  logic [`ID_WORD_W-1:0]   exe_wd_i,
	input  logic                    mem_wreg_i,
	input  logic [`ID_RADDR_W-1:0]  mem_wa_i,
	input  logic [`ID_WORD_W-1:0]   mem_wd_i,
	output id_pkg::alu_op_e         alu_op_o,
	output logic [`ID_WORD_W-1:0]   src1_o,
	output logic [`ID_WORD_W-1:0]   src2_o,
	output logic                    wreg_o,
	output logic [`ID_RADDR_W-1:0]  wa_o,
	output id_pkg::jump_sel_e       jtsel_o,
	output logic [`ID_WORD_W-1:0]   jump_addr_o,
	output logic [`ID_WORD_W-1:0]   ret_addr_o,
	output id_pkg::exc_e            exc_o
);
	import id_pkg::*;

	logic                  load;
	logic [`ID_WORD_W-1:0] cap_inst;
	logic [`ID_WORD_W-1:0] cap_pc;
	logic [`ID_WORD_W-1:0] cap_rs_data;
	logic [`ID_WORD_W-1:0] cap_rt_data;
	logic                  cap_exe_wreg;
	logic [`ID_RADDR_W-1:0] cap_exe_wa;
	logic [`ID_WORD_W-1:0] cap_exe_wd;
	logic                  cap_mem_wreg;
	logic [`ID_RADDR_W-1:0] cap_mem_wa;
	logic [`ID_WORD_W-1:0] cap_mem_wd;

	alu_op_e               dec_alu_op;
	imm_kind_e             dec_imm_kind;
	logic                  dec_rreg1;
	logic                  dec_rreg2;
	logic                  dec_shift;
	logic                  dec_wreg;
	logic [`ID_RADDR_W-1:0] dec_wa;
	logic                  dec_illegal;
	logic [`ID_WORD_W-1:0] src1;
	logic [`ID_WORD_W-1:0] src2;
	jump_sel_e             jtsel;
	logic [`ID_WORD_W-1:0] jump_addr;

	id_capture i_id_capture (
		.cpu_clk_i(cpu_clk_i), .rst_n_i(rst_n_i), .req_i(req_i),
		.inst_i(inst_i), .pc_i(pc_i), .rs_data_i(rs_data_i), .rt_data_i(rt_data_i),
		.exe_wreg_i(exe_wreg_i), .exe_wa_i(exe_wa_i), .exe_wd_i(exe_wd_i),
		.mem_wreg_i(mem_wreg_i), .mem_wa_i(mem_wa_i), .mem_wd_i(mem_wd_i),
		.ack_o(ack_o), .load_o(load),
		.cap_inst_o(cap_inst), .cap_pc_o(cap_pc),
		.cap_rs_data_o(cap_rs_data), .cap_rt_data_o(cap_rt_data),
		.cap_exe_wreg_o(cap_exe_wreg), .cap_exe_wa_o(cap_exe_wa), .cap_exe_wd_o(cap_exe_wd),
		.cap_mem_wreg_o(cap_mem_wreg), .cap_mem_wa_o(cap_mem_wa), .cap_mem_wd_o(cap_mem_wd)
	);

	inst_decode i_inst_decode (
		.inst_i(cap_inst),
		.alu_op_o(dec_alu_op), .rreg1_o(dec_rreg1), .rreg2_o(dec_rreg2),
		.imm_kind_o(dec_imm_kind), .shift_o(dec_shift),
		.wreg_o(dec_wreg), .wa_o(dec_wa), .illegal_o(dec_illegal)
	);

	operand_select i_operand_select (
		.inst_i(cap_inst), .rreg1_i(dec_rreg1), .rreg2_i(dec_rreg2),
		.imm_kind_i(dec_imm_kind), .shift_i(dec_shift),
		.rs_data_i(cap_rs_data), .rt_data_i(cap_rt_data),
		.exe_wreg_i(cap_exe_wreg), .exe_wa_i(cap_exe_wa), .exe_wd_i(cap_exe_wd),
		.mem_wreg_i(cap_mem_wreg), .mem_wa_i(cap_mem_wa), .mem_wd_i(cap_mem_wd),
		.src1_o(src1), .src2_o(src2)
	);

	branch_resolve i_branch_resolve (
		.alu_op_i(dec_alu_op), .pc_i(cap_pc), .inst_i(cap_inst),
		.src1_i(src1), .src2_i(src2),
		.jtsel_o(jtsel), .jump_addr_o(jump_addr)
	);

	id_result i_id_result (
		.cpu_clk_i(cpu_clk_i), .rst_n_i(rst_n_i), .load_i(load),
		.pc_i(cap_pc), .illegal_i(dec_illegal), .alu_op_i(dec_alu_op),
		.src1_i(src1), .src2_i(src2), .wreg_i(dec_wreg), .wa_i(dec_wa),
		.jtsel_i(jtsel), .jump_addr_i(jump_addr),
		.alu_op_o(alu_op_o), .src1_o(src1_o), .src2_o(src2_o),
		.wreg_o(wreg_o), .wa_o(wa_o), .jtsel_o(jtsel_o),
		.jump_addr_o(jump_addr_o), .ret_addr_o(ret_addr_o), .exc_o(exc_o)
	);

endmodule

/* hdl/inst_decode.sv */
`timescale 1ns/1ns
`include "id_settings.svh"

module inst_decode (
	input  logic [`ID_WORD_W-1:0]   inst_i,
	output id_pkg::alu_op_e         alu_op_o,
	output logic                    rreg1_o,
	output logic                    rreg2_o,
	output id_pkg::imm_kind_e       imm_kind_o,
	output logic                    shift_o,
	output logic                    wreg_o,
	output logic [`ID_RADDR_W-1:0]  wa_o,
	output logic                    illegal_o
);
	import id_pkg::*;

	wire [5:0]             opcode = inst_i[31:26];
	wire [5:0]             funct  = inst_i[5:0];
	wire [`ID_RADDR_W-1:0] rt     = inst_i[20:16];
	wire [`ID_RADDR_W-1:0] rd     = inst_i[15:11];
	logic                  imm_form;

	assign imm_form = (opcode[5:3] == 3'b001); // addi .. lui

	always_comb begin
		alu_op_o = OP_NOP;
		case (opcode)
			6'b000000: begin
				case (funct)
					6'b100000: alu_op_o = OP_ADD;
					6'b100001: alu_op_o = OP_ADDU;
					6'b100010: alu_op_o = OP_SUB;
					6'b100011: alu_op_o = OP_SUBU;
					6'b101010: alu_op_o = OP_SLT;
					6'b101011: alu_op_o = OP_SLTU;
					6'b100100: alu_op_o = OP_AND;
					6'b100101: alu_op_o = OP_OR;
					6'b100110: alu_op_o = OP_XOR;
					6'b100111: alu_op_o = OP_NOR;
					6'b000000: alu_op_o = OP_SLL; // also the all-zero nop word
					6'b000010: alu_op_o = OP_SRL;
					6'b000011: alu_op_o = OP_SRA;
					6'b001000: alu_op_o = OP_JR;
					default:   alu_op_o = OP_NOP;
				endcase
			end
			6'b000001: begin
				// regimm group, rt selects the condition
				if (rt == 5'b00001)
					alu_op_o = OP_BGEZ;
				else if (rt == 5'b00000)
					alu_op_o = OP_BLTZ;
			end
			6'b000010: alu_op_o = OP_J;
			6'b000011: alu_op_o = OP_JAL;
			6'b000100: alu_op_o = OP_BEQ;
			6'b000101: alu_op_o = OP_BNE;
			6'b000110: alu_op_o = OP_BLEZ;
			6'b000111: alu_op_o = OP_BGTZ;
			6'b001000: alu_op_o = OP_ADD;  // addi
			6'b001001: alu_op_o = OP_ADDU; // addiu
			6'b001010: alu_op_o = OP_SLT;  // slti
			6'b001011: alu_op_o = OP_SLTU; // sltiu
			6'b001100: alu_op_o = OP_AND;  // andi
			6'b001101: alu_op_o = OP_OR;   // ori
			6'b001110: alu_op_o = OP_XOR;  // xori
			6'b001111: alu_op_o = OP_LUI;
			default:   alu_op_o = OP_NOP;
		endcase
	end

	always_comb begin
		rreg1_o    = 1'b0;
		rreg2_o    = 1'b0;
		imm_kind_o = IMM_NONE;
		shift_o    = 1'b0;
		wreg_o     = 1'b0;
		case (alu_op_o)
			OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_SLT, OP_SLTU,
			OP_AND, OP_OR, OP_XOR, OP_NOR: begin
				rreg1_o = 1'b1;
				wreg_o  = 1'b1;
				if (!imm_form)
					rreg2_o = 1'b1;
				else if (opcode[2])
					imm_kind_o = IMM_ZEXT; // logical immediates
				else
					imm_kind_o = IMM_SEXT;
			end
			OP_LUI: begin
				imm_kind_o = IMM_UPPER;
				wreg_o     = 1'b1;
			end
			OP_SLL, OP_SRL, OP_SRA: begin
				rreg2_o = 1'b1;
				shift_o = 1'b1;
				wreg_o  = 1'b1;
			end
			OP_BEQ, OP_BNE: begin
				rreg1_o = 1'b1;
				rreg2_o = 1'b1;
			end
			OP_BGEZ, OP_BLTZ, OP_BGTZ, OP_BLEZ, OP_JR: rreg1_o = 1'b1;
			OP_JAL: wreg_o = 1'b1;
			default: ; // nop and j
		endcase
	end

	assign wa_o = (alu_op_o == OP_JAL)    ? `ID_RADDR_W'(`ID_LINK_REG) :
	              (imm_kind_o != IMM_NONE) ? rt : rd;

	// no legal encoding decodes to OP_NOP
	assign illegal_o = (alu_op_o == OP_NOP);

endmodule

/* hdl/operand_select.sv */
`timescale 1ns/1ns
`include "id_settings.svh"

module operand_select (
	input  logic [`ID_WORD_W-1:0]   inst_i,
	input  logic                    rreg1_i,
	input  logic                    rreg2_i,
	input  id_pkg::imm_kind_e       imm_kind_i,
	input  logic                    shift_i,
	input  logic [`ID_WORD_W-1:0]   rs_data_i,
	input  logic [`ID_WORD_W-1:0]   rt_data_i,
	input  logic                    exe_wreg_i,
	input  logic [`ID_RADDR_W-1:0]  exe_wa_i,
	input  logic [`ID_WORD_W-1:0]   exe_wd_i,
	input  logic                    mem_wreg_i,
	input  logic [`ID_RADDR_W-1:0]  mem_wa_i,
	input  logic [`ID_WORD_W-1:0]   mem_wd_i,
	output logic [`ID_WORD_W-1:0]   src1_o,
	output logic [`ID_WORD_W-1:0]   src2_o
);
	import id_pkg::*;

	wire [`ID_RADDR_W-1:0] rs  = inst_i[25:21];
	wire [`ID_RADDR_W-1:0] rt  = inst_i[20:16];
	wire [4:0]             sa  = inst_i[10:6];
	wire [15:0]            imm = inst_i[15:0];

	fwd_sel_e              fwd1;
	fwd_sel_e              fwd2;
	logic [`ID_WORD_W-1:0] rs_val;
	logic [`ID_WORD_W-1:0] rt_val;
	logic [`ID_WORD_W-1:0] imm_val;

	// execute is younger than memory, so it wins; r0 is never forwarded
	function automatic fwd_sel_e pick_src(input logic [`ID_RADDR_W-1:0] ra);
		if (exe_wreg_i && exe_wa_i == ra && ra != '0)
			return FWD_EXE;
		if (mem_wreg_i && mem_wa_i == ra && ra != '0)
			return FWD_MEM;
		return FWD_REG;
	endfunction

	function automatic logic [`ID_WORD_W-1:0] fwd_value(input fwd_sel_e sel,
		input logic [`ID_WORD_W-1:0] rf_val);
		case (sel)
			FWD_EXE: return exe_wd_i;
			FWD_MEM: return mem_wd_i;
			default: return rf_val;
		endcase
	endfunction

	assign fwd1   = pick_src(rs);
	assign fwd2   = pick_src(rt);
	assign rs_val = fwd_value(fwd1, rs_data_i);
	assign rt_val = fwd_value(fwd2, rt_data_i);

	always_comb begin
		case (imm_kind_i)
			IMM_SEXT:  imm_val = {{(`ID_WORD_W-16){imm[15]}}, imm};
			IMM_ZEXT:  imm_val = {{(`ID_WORD_W-16){1'b0}}, imm};
			IMM_UPPER: imm_val = {imm, 16'h0000}; // lui
			default:   imm_val = '0;
		endcase
	end

	assign src1_o = shift_i ? {{(`ID_WORD_W-5){1'b0}}, sa} :
	                rreg1_i ? rs_val : '0;
	assign src2_o = (imm_kind_i != IMM_NONE) ? imm_val :
	                rreg2_i ? rt_val : '0;

endmodule

/* list.f */
+incdir+hdl
hdl/id_pkg.sv
hdl/id_capture.sv
hdl/inst_decode.sv
hdl/operand_select.sv
hdl/branch_resolve.sv
hdl/id_result.sv
hdl/id_stage.sv
testbench/tb_id_stage.sv

/* testbench/tb_id_stage.sv */
`timescale 1ns/1ns
`include "id_settings.svh"

module tb_id_stage;
	import id_pkg::*;

	typedef logic [`ID_WORD_W-1:0]  word_t;
	typedef logic [`ID_RADDR_W-1:0] addr_t;

	localparam int    ACK_TIMEOUT = 20;
	localparam word_t RF_RS = 32'h1111_1111;
	localparam word_t RF_RT = 32'h2222_2222;
	localparam word_t EXE_D = 32'heeee_0001;
	localparam word_t MEM_D = 32'hdddd_0002;

	logic      cpu_clk;
	logic      rst_n;
	logic      req;
	logic      ack;
	word_t     inst;
	word_t     pc;
	word_t     rs_data;
	word_t     rt_data;
	logic      exe_wreg;
	addr_t     exe_wa;
	word_t     exe_wd;
	logic      mem_wreg;
	addr_t     mem_wa;
	word_t     mem_wd;
	alu_op_e   alu_op;
	word_t     src1;
	word_t     src2;
	logic      wreg;
	addr_t     wa;
	jump_sel_e jtsel;
	word_t     jump_addr;
	word_t     ret_addr;
	exc_e      exc;

	integer      seed = 11;
	int          errors = 0;
	int          checks = 0;
	int          tests = 0;
	addr_t       rs_a;
	addr_t       rt_a;
	addr_t       rd_a;
	logic [15:0] imm16;

	// mips encodings of the kept instructions
	logic [5:0] r_funct [10] = '{6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27,
		6'h2a, 6'h2b};
	alu_op_e    r_ops [10] = '{OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_AND, OP_OR, OP_XOR,
		OP_NOR, OP_SLT, OP_SLTU};
	logic [5:0] i_opc [7] = '{6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e};
	alu_op_e    i_ops [7] = '{OP_ADD, OP_ADDU, OP_SLT, OP_SLTU, OP_AND, OP_OR, OP_XOR};
	logic       i_zext [7] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1};
	logic [5:0] s_funct [3] = '{6'h00, 6'h02, 6'h03};
	alu_op_e    s_ops [3] = '{OP_SLL, OP_SRL, OP_SRA};

	id_stage i_id_stage (
		.cpu_clk_i(cpu_clk), .rst_n_i(rst_n), .req_i(req), .ack_o(ack),
		.inst_i(inst), .pc_i(pc), .rs_data_i(rs_data), .rt_data_i(rt_data),
		.exe_wreg_i(exe_wreg), .exe_wa_i(exe_wa), .exe_wd_i(exe_wd),
		.mem_wreg_i(mem_wreg), .mem_wa_i(mem_wa), .mem_wd_i(mem_wd),
		.alu_op_o(alu_op), .src1_o(src1), .src2_o(src2), .wreg_o(wreg), .wa_o(wa),
		.jtsel_o(jtsel), .jump_addr_o(jump_addr), .ret_addr_o(ret_addr), .exc_o(exc)
	);

	always #10 cpu_clk = ~cpu_clk;

	function automatic word_t enc_r(input addr_t rs, rt, rd, sa, input logic [5:0] fn);
		return {6'h00, rs, rt, rd, sa, fn};
	endfunction

	function automatic word_t enc_i(input logic [5:0] op, input addr_t rs, rt,
		input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t enc_j(input logic [5:0] op, input logic [25:0] idx);
		return {op, idx};
	endfunction

	task automatic compare_word(input string name, input word_t exp, input word_t act);
		checks++;
		if (act !== exp) begin
			$display("MISMATCH at %0t: %s expected %h got %h", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic compare_addr(input string name, input addr_t exp, input addr_t act);
		checks++;
		if (act !== exp) begin
			$display("MISMATCH at %0t: %s expected %0d got %0d", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic compare_bit(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			$display("MISMATCH at %0t: %s expected %b got %b", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic compare_op(input string name, input alu_op_e exp, input alu_op_e act);
		checks++;
		if (act !== exp) begin
			$display("MISMATCH at %0t: %s expected %s got %s", $time, name, exp.name(),
				act.name());
			errors++;
		end
	endtask

	task automatic compare_jsel(input string name, input jump_sel_e exp, input jump_sel_e act);
		checks++;
		if (act !== exp) begin
			$display("MISMATCH at %0t: %s expected %s got %s", $time, name, exp.name(),
				act.name());
			errors++;
		end
	endtask

	task automatic compare_exc(input string name, input exc_e exp, input exc_e act);
		checks++;
		if (act !== exp) begin
			$display("MISMATCH at %0t: %s expected %s got %s", $time, name, exp.name(),
				act.name());
			errors++;
		end
	endtask

	task automatic check_all(input alu_op_e op, input word_t s1, s2, input logic wr,
		input addr_t wa_exp, input jump_sel_e js, input word_t ja, input exc_e ex);
		compare_op("alu_op_o", op, alu_op);
		compare_word("src1_o", s1, src1);
		compare_word("src2_o", s2, src2);
		compare_bit("wreg_o", wr, wreg);
		if (wr)
			compare_addr("wa_o", wa_exp, wa); // don't care without a write
		compare_jsel("jtsel_o", js, jtsel);
		compare_word("jump_addr_o", ja, jump_addr);
		compare_word("ret_addr_o", pc + 32'd8, ret_addr);
		compare_exc("exc_o", ex, exc);
	endtask

	task automatic wait_ack(input logic level, output int cycles, output bit ok);
		cycles = 0;
		ok = 1'b0;
		while (!ok && cycles < ACK_TIMEOUT) begin
			@(negedge cpu_clk);
			cycles++;
			ok = (ack === level);
		end
		if (!ok) begin
			$display("ERROR at %0t: ack did not go to %b within %0d cycles", $time, level,
				ACK_TIMEOUT);
			errors++;
		end
	endtask

	// one full four-phase exchange, results hold afterwards
	task automatic run_txn(output int lat);
		int n;
		bit ok;
		@(negedge cpu_clk);
		req = 1'b1;
		wait_ack(1'b1, lat, ok);
		req = 1'b0;
		wait_ack(1'b0, n, ok);
	endtask

	task automatic set_fwd_off();
		exe_wreg = 1'b0;
		exe_wa   = '0;
		exe_wd   = '0;
		mem_wreg = 1'b0;
		mem_wa   = '0;
		mem_wd   = '0;
	endtask

	task automatic randomize_inputs();
		word_t r;
		r = $random(seed);
		rs_a  = r[4:0];
		rt_a  = r[9:5];
		rd_a  = r[14:10];
		imm16 = r[31:16];
		rs_data = $random(seed);
		rt_data = $random(seed);
		r = $random(seed);
		pc = {r[31:2], 2'b00};
	endtask

	task automatic finish_test(input string name, input int e0);
		tests++;
		if (errors == e0)
			$display("%-20s ok", name);
		else
			$display("%-20s %0d errors", name, errors - e0);
	endtask

	task automatic test_handshake();
		int e0;
		int lat;
		int n;
		bit ok;
		e0 = errors;
		compare_bit("ack_o", 1'b0, ack);
		compare_bit("wreg_o", 1'b0, wreg);
		compare_jsel("jtsel_o", JT_SEQ, jtsel);
		compare_op("alu_op_o", OP_NOP, alu_op);
		compare_exc("exc_o", EXC_NONE, exc);
		set_fwd_off();
		pc      = 32'h0040_0000;
		rs_data = 32'h0000_1234;
		rt_data = 32'h0000_4321;
		inst    = enc_r(5'd1, 5'd2, 5'd3, 5'd0, 6'h21); // addu r3, r1, r2
		@(negedge cpu_clk);
		req = 1'b1;
		wait_ack(1'b1, lat, ok);
		compare_word("ack latency", 32'd2, word_t'(lat));
		repeat (4) begin
			@(negedge cpu_clk);
			compare_bit("ack_o held", 1'b1, ack);
		end
		req = 1'b0;
		wait_ack(1'b0, n, ok);
		repeat (4) begin
			@(negedge cpu_clk);
			compare_bit("ack_o idle", 1'b0, ack);
		end
		check_all(OP_ADDU, rs_data, rt_data, 1'b1, 5'd3, JT_SEQ, '0, EXC_NONE);
		finish_test("reset and handshake", e0);
	endtask

	task automatic test_arith();
		int e0;
		int lat;
		word_t ival;
		e0 = errors;
		set_fwd_off();
		for (int k = 0; k < 10; k++) begin
			randomize_inputs();
			inst = enc_r(rs_a, rt_a, rd_a, 5'd0, r_funct[k]);
			run_txn(lat);
			check_all(r_ops[k], rs_data, rt_data, 1'b1, rd_a, JT_SEQ, '0, EXC_NONE);
		end
		for (int k = 0; k < 7; k++) begin
			randomize_inputs();
			inst = enc_i(i_opc[k], rs_a, rt_a, imm16);
			ival = i_zext[k] ? {16'h0000, imm16} : {{16{imm16[15]}}, imm16};
			run_txn(lat);
			check_all(i_ops[k], rs_data, ival, 1'b1, rt_a, JT_SEQ, '0, EXC_NONE);
		end
		randomize_inputs();
		inst = enc_i(6'h0f, 5'd0, rt_a, imm16); // lui
		run_txn(lat);
		check_all(OP_LUI, '0, {imm16, 16'h0000}, 1'b1, rt_a, JT_SEQ, '0, EXC_NONE);
		for (int k = 0; k < 3; k++) begin
			randomize_inputs();
			inst = enc_r(5'd0, rt_a, rd_a, imm16[4:0], s_funct[k]);
			run_txn(lat);
			check_all(s_ops[k], {27'h0, imm16[4:0]}, rt_data, 1'b1, rd_a, JT_SEQ, '0,
				EXC_NONE);
		end
		finish_test("arith and shifts", e0);
	endtask

	task automatic fwd_case(input addr_t rs, rt, input logic ewr, input addr_t ewa,
		input logic mwr, input addr_t mwa, input word_t exp1, exp2);
		int lat;
		inst     = enc_r(rs, rt, 5'd4, 5'd0, 6'h21);
		exe_wreg = ewr;
		exe_wa   = ewa;
		mem_wreg = mwr;
		mem_wa   = mwa;
		run_txn(lat);
		check_all(OP_ADDU, exp1, exp2, 1'b1, 5'd4, JT_SEQ, '0, EXC_NONE);
	endtask

	task automatic test_forwarding();
		int e0;
		e0 = errors;
		pc      = 32'h0000_1000;
		rs_data = RF_RS;
		rt_data = RF_RT;
		exe_wd  = EXE_D;
		mem_wd  = MEM_D;
		fwd_case(5'd5, 5'd6, 1'b1, 5'd5, 1'b1, 5'd5, EXE_D, RF_RT); // exe over mem
		fwd_case(5'd5, 5'd6, 1'b1, 5'd7, 1'b1, 5'd6, RF_RS, MEM_D);
		fwd_case(5'd5, 5'd6, 1'b1, 5'd6, 1'b1, 5'd6, RF_RS, EXE_D);
		fwd_case(5'd5, 5'd6, 1'b0, 5'd5, 1'b0, 5'd6, RF_RS, RF_RT); // no write enable
		fwd_case(5'd0, 5'd0, 1'b1, 5'd0, 1'b1, 5'd0, RF_RS, RF_RT); // r0 stays put
		fwd_case(5'd5, 5'd5, 1'b0, 5'd5, 1'b1, 5'd5, MEM_D, MEM_D);
		set_fwd_off();
		finish_test("forwarding", e0);
	endtask

	task automatic branch_case(input logic [5:0] opc, input addr_t rt, input alu_op_e op,
		input word_t a, b, input bit taken, input bit two_src);
		int lat;
		word_t target;
		word_t s2;
		randomize_inputs();
		rs_data = a;
		if (two_src)
			rt_data = b; // rt stays random where it is not read
		inst    = enc_i(opc, 5'd8, rt, imm16);
		target  = pc + 32'd4 + {{14{imm16[15]}}, imm16, 2'b00};
		s2      = two_src ? b : '0;
		run_txn(lat);
		if (taken)
			check_all(op, a, s2, 1'b0, '0, JT_BRANCH, target, EXC_NONE);
		else
			check_all(op, a, s2, 1'b0, '0, JT_SEQ, '0, EXC_NONE);
	endtask

	task automatic test_branches();
		int e0;
		word_t w;
		e0 = errors;
		set_fwd_off();
		w = $random(seed);
		branch_case(6'h04, 5'd9, OP_BEQ, w, w, 1'b1, 1'b1);
		branch_case(6'h04, 5'd9, OP_BEQ, w, w ^ 32'd1, 1'b0, 1'b1);
		branch_case(6'h05, 5'd9, OP_BNE, w, ~w, 1'b1, 1'b1);
		branch_case(6'h05, 5'd9, OP_BNE, w, w, 1'b0, 1'b1);
		branch_case(6'h01, 5'd1, OP_BGEZ, 32'h0000_0000, '0, 1'b1, 1'b0);
		branch_case(6'h01, 5'd1, OP_BGEZ, 32'hffff_fff0, '0, 1'b0, 1'b0);
		branch_case(6'h01, 5'd0, OP_BLTZ, 32'h8000_0000, '0, 1'b1, 1'b0);
		branch_case(6'h01, 5'd0, OP_BLTZ, 32'h0000_0007, '0, 1'b0, 1'b0);
		branch_case(6'h07, 5'd0, OP_BGTZ, 32'h0000_0003, '0, 1'b1, 1'b0);
		branch_case(6'h07, 5'd0, OP_BGTZ, 32'h0000_0000, '0, 1'b0, 1'b0);
		branch_case(6'h06, 5'd0, OP_BLEZ, 32'h0000_0000, '0, 1'b1, 1'b0);
		branch_case(6'h06, 5'd0, OP_BLEZ, 32'h0000_0001, '0, 1'b0, 1'b0);
		finish_test("branches", e0);
	endtask

	task automatic test_jumps();
		int e0;
		int lat;
		word_t r;
		word_t pc4;
		word_t target;
		e0 = errors;
		set_fwd_off();
		randomize_inputs();
		r      = $random(seed);
		pc4    = pc + 32'd4;
		target = {pc4[31:28], r[25:0], 2'b00};
		inst   = enc_j(6'h02, r[25:0]);
		run_txn(lat);
		check_all(OP_J, '0, '0, 1'b0, '0, JT_ABS, target, EXC_NONE);
		inst = enc_j(6'h03, r[25:0]); // jal links to r31
		run_txn(lat);
		check_all(OP_JAL, '0, '0, 1'b1, 5'd31, JT_ABS, target, EXC_NONE);
		exe_wreg = 1'b1;
		exe_wa   = 5'd9;
		exe_wd   = {r[31:2], 2'b00};
		inst     = enc_r(5'd9, 5'd0, 5'd0, 5'd0, 6'h08); // jr r9, forwarded
		run_txn(lat);
		check_all(OP_JR, exe_wd, '0, 1'b0, '0, JT_REG, exe_wd, EXC_NONE);
		set_fwd_off();
		finish_test("jumps", e0);
	endtask

	task automatic test_reserved();
		int e0;
		int lat;
		word_t bad [5];
		e0 = errors;
		set_fwd_off();
		randomize_inputs();
		bad[0] = 32'hfc00_0000;
		bad[1] = enc_i(6'h23, rs_a, rt_a, imm16);      // lw, dropped
		bad[2] = enc_r(rs_a, rt_a, 5'd0, 5'd0, 6'h18); // mult
		bad[3] = enc_i(6'h01, rs_a, 5'h11, imm16);     // bgezal
		bad[4] = enc_r(rs_a, 5'd0, 5'd31, 5'd0, 6'h09); // jalr
		for (int k = 0; k < 5; k++) begin
			inst = bad[k];
			run_txn(lat);
			check_all(OP_NOP, '0, '0, 1'b0, '0, JT_SEQ, '0, EXC_RI);
		end
		finish_test("reserved instruction", e0);
	endtask

	initial begin
		cpu_clk = 1'b0;
		rst_n   = 1'b0;
		req     = 1'b0;
		inst    = '0;
		pc      = '0;
		rs_data = '0;
		rt_data = '0;
		set_fwd_off();
		repeat (4) @(posedge cpu_clk);
		@(negedge cpu_clk);
		rst_n = 1'b1;

		test_handshake();
		test_arith();
		test_forwarding();
		test_branches();
		test_jumps();
		test_reserved();

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule
